/* buffer_settings.svh */
`ifndef BUFFER_SETTINGS_SVH
`define BUFFER_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// gather buffer sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define BUF_FEAT_WORDS 64   // feature bank depth
`define BUF_IDX_WORDS  64   // index bank depth

// both banks share one address width
`define BUF_ADDR_BITS  6

// one feature word is this many 8-bit lanes
`define BUF_FEAT_BYTES 16

`endif

/* buffer_pkg.sv */
`include "buffer_settings.svh"

package buffer_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bank words
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [`BUF_ADDR_BITS-1:0] buf_addr_t;

    typedef logic [`BUF_FEAT_BYTES-1:0][7:0] feat_word_t;  // 128 bits

    // one entry of the gather list
    typedef struct packed {
        logic      last;       // final entry of the list
        buf_addr_t feat_addr;
    } gather_entry_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic       en;
        buf_addr_t  addr;
        feat_word_t data;
    } feat_wr_t;

    typedef struct packed {
        logic          en;
        buf_addr_t     addr;
        gather_entry_t entry;
    } idx_wr_t;

    typedef struct packed {
        logic       valid;
        logic       last;      // only meaningful with valid
        feat_word_t data;
    } gather_out_t;

endpackage

/* sram_macro.sv */
// behavioural model of a single-port sram macro
// csb and web are active low, do_q is registered

module sram_macro #(
    parameter type word_t = buffer_pkg::feat_word_t,
    parameter int  DEPTH  = 64
) (
    input  logic                  clk,
    input  logic                  csb,
    input  logic                  web,
    input  buffer_pkg::buf_addr_t a,
    input  word_t                 di,
    output word_t                 do_q
);

    word_t mem [DEPTH];

    // one access per cycle, the write path also drives the output
    always_ff @(posedge clk) begin
        if (!csb) begin
            if (!web) begin
                mem[a] <= di;
                do_q   <= di;       // write-through
            end else begin
                do_q   <= mem[a];
            end
        end
    end

endmodule

/* delay_line.sv */
// fixed-length shift register
// every stage clears on reset

module delay_line #(
    parameter int STAGES = 1,
    parameter int WIDTH  = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] pipe [STAGES];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= din;
            for (int i = 1; i < STAGES; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign dout = pipe[STAGES-1];   // oldest stage

endmodule

/* sram_port.sv */
// bank wrapper around one sram_macro
// write beats read on the shared address, last read word is held

module sram_port #(
    parameter type word_t = buffer_pkg::feat_word_t,
    parameter int  DEPTH  = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  read_en,
    input  logic                  write_en,
    input  buffer_pkg::buf_addr_t addr_r,
    input  buffer_pkg::buf_addr_t addr_w,
    input  word_t                 data_in,
    output word_t                 data_out,
    output logic                  rd_valid
);

    import buffer_pkg::*;

    buf_addr_t addr;
    logic      csb;
    logic      web;
    logic      rd_issue;
    word_t     do_q;
    word_t     hold_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // macro control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign addr     = write_en ? addr_w : addr_r;
    assign web      = ~write_en;
    assign csb      = ~(write_en | read_en);
    assign rd_issue = read_en & ~write_en;     // a write steals the port

    sram_macro #(
        .word_t (word_t),
        .DEPTH  (DEPTH)
    ) macro_inst (
        .clk  (clk),
        .csb  (csb),
        .web  (web),
        .a    (addr),
        .di   (data_in),
        .do_q (do_q)
    );

    delay_line #(
        .STAGES (1),
        .WIDTH  (1)
    ) rd_dly_inst (
        .clk  (clk),
        .rst  (rst),
        .din  (rd_issue),
        .dout (rd_valid)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output hold
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            hold_q <= do_q;
        end
    end

    assign data_out = rd_valid ? do_q : hold_q;   // bypass on the read beat

endmodule

/* gather_engine.sv */
// walks the index list and turns each entry into a feature read
//
// stage one  reads index[base + i]
// stage two  reads feature[entry.feat_addr] one beat later
// both stages hold while a host write owns the banks

module gather_engine (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      stall,
    input  buffer_pkg::buf_addr_t     base,
    input  buffer_pkg::gather_entry_t entry,
    output logic                      idx_rd_en,
    output buffer_pkg::buf_addr_t     idx_addr,
    output logic                      feat_rd_en,
    output buffer_pkg::buf_addr_t     feat_addr,
    output logic                      last_issue,
    output logic                      busy
);

    import buffer_pkg::*;

    buf_addr_t ptr_q;          // next index address
    logic      busy_q;
    logic      armed_q;        // entry on the index port is unconsumed
    logic      stopping_q;     // last feature read has gone out

    logic      run;
    logic      feat_go;
    logic      last_go;
    logic      idx_go;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // issue decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign run     = busy_q & ~stopping_q & ~stall;
    assign feat_go = run & armed_q;             // stage two
    assign last_go = feat_go & entry.last;

    // stage one keeps going until the last entry is consumed
    assign idx_go  = run & ~last_go;

    assign idx_rd_en  = idx_go;
    assign idx_addr   = ptr_q;
    assign feat_rd_en = feat_go;
    assign feat_addr  = entry.feat_addr;
    assign last_issue = last_go;
    assign busy       = busy_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // run control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q     <= 1'b0;
            stopping_q <= 1'b0;
        end else if (!busy_q) begin
            busy_q <= start;                    // start only counts when idle
        end else if (stopping_q) begin
            // one drain beat for the final feature word
            busy_q     <= 1'b0;
            stopping_q <= 1'b0;
        end else if (!stall) begin
            stopping_q <= last_go;
        end
    end

    // entry tracking between the two stages
    always_ff @(posedge clk) begin
        if (rst) begin
            armed_q <= 1'b0;
        end else if (!busy_q) begin
            armed_q <= 1'b0;
        end else if (!stall && !stopping_q) begin
            armed_q <= idx_go;   // a fresh index read lands next beat
        end
    end

    // list pointer, wraps at the bank end
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr_q <= '0;
        end else if (!busy_q) begin
            if (start) begin
                ptr_q <= base;
            end
        end else if (idx_go) begin
            ptr_q <= ptr_q + buf_addr_t'(1);
        end
    end

endmodule

/* gather_buffer_top.sv */
`include "buffer_settings.svh"

// gather buffer
// feature bank + index bank + gather engine

module gather_buffer_top (
    input  logic                    clk,
    input  logic                    rst,
    input  buffer_pkg::feat_wr_t    feat_wr,
    input  buffer_pkg::idx_wr_t     idx_wr,
    input  logic                    start,
    input  buffer_pkg::buf_addr_t   base,
    output buffer_pkg::gather_out_t gather_out,
    output logic                    busy
);

    import buffer_pkg::*;

    logic          stall;
    logic          idx_rd_en;
    logic          feat_rd_en;
    logic          last_issue;
    logic          feat_valid;
    logic          feat_last;
    buf_addr_t     idx_addr;
    buf_addr_t     feat_addr;
    gather_entry_t idx_entry;
    feat_word_t    feat_data;

    // host writes take the bank port for that cycle
    assign stall = feat_wr.en | idx_wr.en;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // banks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    sram_port #(
        .word_t (gather_entry_t),
        .DEPTH  (`BUF_IDX_WORDS)
    ) idx_port_inst (
        .clk      (clk),
        .rst      (rst),
        .read_en  (idx_rd_en),
        .write_en (idx_wr.en),
        .addr_r   (idx_addr),
        .addr_w   (idx_wr.addr),
        .data_in  (idx_wr.entry),
        .data_out (idx_entry),
        .rd_valid ()                 // engine tracks this itself
    );

    sram_port #(
        .word_t (feat_word_t),
        .DEPTH  (`BUF_FEAT_WORDS)
    ) feat_port_inst (
        .clk      (clk),
        .rst      (rst),
        .read_en  (feat_rd_en),
        .write_en (feat_wr.en),
        .addr_r   (feat_addr),
        .addr_w   (feat_wr.addr),
        .data_in  (feat_wr.data),
        .data_out (feat_data),
        .rd_valid (feat_valid)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // engine and output
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    gather_engine gather_engine_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .stall      (stall),
        .base       (base),
        .entry      (idx_entry),
        .idx_rd_en  (idx_rd_en),
        .idx_addr   (idx_addr),
        .feat_rd_en (feat_rd_en),
        .feat_addr  (feat_addr),
        .last_issue (last_issue),
        .busy       (busy)
    );

    // last rides one beat behind its feature read, same as rd_valid
    delay_line #(
        .STAGES (1),
        .WIDTH  (1)
    ) last_dly_inst (
        .clk  (clk),
        .rst  (rst),
        .din  (last_issue),
        .dout (feat_last)
    );

    assign gather_out.valid = feat_valid;
    assign gather_out.last  = feat_last;
    assign gather_out.data  = feat_data;

endmodule

/* gather_tb.sv */
`include "buffer_settings.svh"

module gather_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import buffer_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 2;
    localparam int GATHER_LIMIT = 1000;   // cycles per gather
    localparam int LINE_LIMIT   = 500;

    logic        clk;
    logic        rst;
    feat_wr_t    feat_wr;
    idx_wr_t     idx_wr;
    logic        start;
    buf_addr_t   base;
    gather_out_t gather_out;
    logic        busy;

    // host-side copies of both banks
    feat_word_t    feat_model [`BUF_FEAT_WORDS];
    gather_entry_t idx_model  [`BUF_IDX_WORDS];
    feat_word_t    expected_q [$];

    logic [31:0] rand_state;
    int          error_count;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    bit          run_aborted;

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    gather_buffer_top gather_buffer_top_inst (
        .clk        (clk),
        .rst        (rst),
        .feat_wr    (feat_wr),
        .idx_wr     (idx_wr),
        .start      (start),
        .base       (base),
        .gather_out (gather_out),
        .busy       (busy)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    task automatic count_error();
        error_count++;
        test_errors++;
    endtask

    task automatic check_item(input gather_out_t got, input gather_out_t exp, input string what);
        if (got.valid !== exp.valid || got.last !== exp.last ||
            (exp.valid && got.data !== exp.data)) begin
            $display("[FAIL] %0d ns %s: got valid %b last %b data %h, expected %b %b %h",
                     $time, what, got.valid, got.last, got.data,
                     exp.valid, exp.last, exp.data);
            count_error();
        end
    endtask

    task automatic check_busy(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0d ns %s: busy is %b, expected %b", $time, what, got, exp);
            count_error();
        end
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", tests_run, name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic end_run();
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (!run_aborted && error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    task automatic abort_run(input string why);
        $display("run stopped at %0d ns because %s", $time, why);
        run_aborted = 1'b1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host drive
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic load_feature(input buf_addr_t a, input feat_word_t d);
        @(posedge clk);
        feat_wr.en   <= 1'b1;
        feat_wr.addr <= a;
        feat_wr.data <= d;
        feat_model[a] = d;
        @(posedge clk);
        feat_wr.en <= 1'b0;
    endtask

    task automatic load_index(input buf_addr_t a, input gather_entry_t e);
        @(posedge clk);
        idx_wr.en    <= 1'b1;
        idx_wr.addr  <= a;
        idx_wr.entry <= e;
        idx_model[a] = e;
        @(posedge clk);
        idx_wr.en <= 1'b0;
    endtask

    // random host writes into the top eight words of each bank
    task automatic drive_stall_writes(input int density);
        logic [31:0]   r;
        feat_word_t    w;
        gather_entry_t e;
        bit            do_feat;
        bit            do_idx;

        r       = next_rand();
        do_feat = 1'b0;
        do_idx  = 1'b0;
        if (int'(r[30:16]) % 100 < density) begin
            do_feat = (r[9:8] != 2'd1);     // r[9:8] picks the bank
            do_idx  = (r[9:8] != 2'd0);
        end
        w           = {next_rand(), next_rand(), next_rand(), next_rand()};
        e.last      = r[6];
        e.feat_addr = r[15:10];
        feat_wr.en   <= do_feat;
        feat_wr.addr <= {3'b111, r[2:0]};
        feat_wr.data <= w;
        idx_wr.en    <= do_idx;
        idx_wr.addr  <= {3'b111, r[5:3]};
        idx_wr.entry <= e;
        if (do_feat) begin
            feat_model[{3'b111, r[2:0]}] = w;
        end
        if (do_idx) begin
            idx_model[{3'b111, r[5:3]}] = e;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_idle(input int cycles);
        gather_out_t idle_exp;

        idle_exp = '0;
        tests_run++;
        test_errors = 0;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_busy(busy, 1'b0, "busy after reset");
            check_item(gather_out, idle_exp, "output after reset");
        end
        report_test("idle after reset");
    endtask

    // walk the model list up to its last entry
    task automatic build_expected(input buf_addr_t b, output int n);
        buf_addr_t p;
        bit        found;

        expected_q.delete();
        p     = b;
        found = 1'b0;
        for (int i = 0; i < `BUF_IDX_WORDS && !found; i++) begin
            expected_q.push_back(feat_model[idx_model[p].feat_addr]);
            found = idx_model[p].last;
            p     = p + buf_addr_t'(1);
        end
        n = expected_q.size();
        if (!found) begin
            abort_run("a gather list in the case file never sets last");
        end
    endtask

    task automatic run_gather(input buf_addr_t b, input int density, input bit restart);
        int          n_exp;
        int          n_got;
        int          cycle;
        int          prev_cycle;
        bit          seen_busy;
        bit          done;
        gather_out_t exp;
        gather_out_t got;

        build_expected(b, n_exp);
        if (run_aborted) begin
            return;
        end
        tests_run++;
        test_errors = 0;
        n_got       = 0;
        cycle       = 0;
        prev_cycle  = -1;
        seen_busy   = 1'b0;
        done        = 1'b0;

        @(posedge clk);
        start <= 1'b1;
        base  <= b;
        drive_stall_writes(density);
        while (!done) begin
            @(negedge clk);
            got = gather_out;
            if (got.valid) begin
                if (expected_q.size() == 0) begin
                    $display("[FAIL] %0d ns extra item %h after the list", $time, got.data);
                    count_error();
                end else begin
                    exp.valid = 1'b1;
                    exp.last  = (n_got == n_exp - 1);
                    exp.data  = expected_q.pop_front();
                    check_item(got, exp, $sformatf("item %0d", n_got));
                end
                if (n_got == 0 && cycle < 3) begin
                    $display("[FAIL] %0d ns first item only %0d cycles after start",
                             $time, cycle);
                    count_error();
                end
                if (density == 0 && n_got > 0 && cycle != prev_cycle + 1) begin
                    $display("[FAIL] %0d ns gap before item %0d without stalls", $time, n_got);
                    count_error();
                end
                prev_cycle = cycle;
                n_got++;
            end
            if (cycle == 1) begin
                check_busy(busy, 1'b1, "busy after start");
            end
            if (busy) begin
                seen_busy = 1'b1;
            end else if (seen_busy) begin
                done = 1'b1;
            end
            if (!done) begin
                cycle++;
                if (cycle > GATHER_LIMIT) begin
                    count_error();
                    report_test($sformatf("gather base %h density %0d", b, density));
                    abort_run("a gather did not finish in time");
                    return;
                end
                @(posedge clk);
                start <= restart && cycle == 2;     // ignored, engine is busy
                if (restart && cycle == 2) begin
                    base <= b + buf_addr_t'(7);
                end
                drive_stall_writes(density);
            end
        end
        if (prev_cycle != cycle - 1) begin
            $display("[FAIL] %0d ns busy did not fall right after the last item", $time);
            count_error();
        end
        if (n_got != n_exp) begin
            $display("[FAIL] %0d ns got %0d items, expected %0d", $time, n_got, n_exp);
            count_error();
        end
        @(posedge clk);
        start      <= 1'b0;
        feat_wr.en <= 1'b0;
        idx_wr.en  <= 1'b0;
        report_test($sformatf("gather base %h density %0d, %0d items", b, density, n_got));
    endtask

    task automatic run_cases();
        int            fd;
        int            n_fields;
        int            line_no;
        int            density;
        int            restart;
        string         line;
        string         rest;
        byte           cmd;
        logic [31:0]   a_v;
        logic [31:0]   l_v;
        logic [31:0]   f_v;
        logic [127:0]  d_v;
        gather_entry_t e;

        fd = $fopen("gather_cases.txt", "r");
        if (fd == 0) begin
            abort_run("gather_cases.txt could not be opened");
            return;
        end
        line_no = 0;
        while (!$feof(fd) && !run_aborted) begin
            line_no++;
            if (line_no > LINE_LIMIT) begin
                abort_run("the case file has too many lines");
                break;
            end
            line     = "";
            n_fields = $fgets(line, fd);
            if (line.len() < 2) begin
                continue;
            end
            cmd  = line.getc(0);
            rest = line.substr(2, line.len() - 1);
            if (cmd == "#") begin
                continue;
            end else if (cmd == "F") begin
                n_fields = $sscanf(rest, "%h %h", a_v, d_v);
                if (n_fields != 2) begin
                    abort_run($sformatf("line %0d of the case file cannot be parsed", line_no));
                end else begin
                    load_feature(a_v[5:0], d_v);
                end
            end else if (cmd == "I") begin
                n_fields    = $sscanf(rest, "%h %d %h", a_v, l_v, f_v);
                e.last      = l_v[0];
                e.feat_addr = f_v[5:0];
                if (n_fields != 3) begin
                    abort_run($sformatf("line %0d of the case file cannot be parsed", line_no));
                end else begin
                    load_index(a_v[5:0], e);
                end
            end else if (cmd == "G") begin
                n_fields = $sscanf(rest, "%h %d %d", a_v, density, restart);
                if (n_fields != 3) begin
                    abort_run($sformatf("line %0d of the case file cannot be parsed", line_no));
                end else begin
                    run_gather(a_v[5:0], density, restart != 0);
                end
            end else begin
                abort_run($sformatf("line %0d of the case file has an unknown command", line_no));
            end
        end
        $fclose(fd);
    endtask

    initial begin
        rand_state   = 32'd98;
        error_count  = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        run_aborted  = 1'b0;
        rst     <= 1'b1;
        feat_wr <= '0;
        idx_wr  <= '0;
        start   <= 1'b0;
        base    <= '0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
        end
        rst <= 1'b0;
        check_idle(4);
        run_cases();
        end_run();
    end

endmodule

/* gather_cases.txt */
# F <addr> <data>                 feature load, 128-bit hex word
# I <addr> <last> <feat_addr>     index load, last is 0 or 1
# G <base> <density> <restart>    gather, stall density in percent, restart 1 repeats start
F 00 0f0e0d0c0b0a09080706050403020100
F 01 1f1e1d1c1b1a19181716151413121110
F 02 2f2e2d2c2b2a29282726252423222120
F 03 3f3e3d3c3b3a39383736353433323130
F 04 4f4e4d4c4b4a49484746454443424140
F 05 5f5e5d5c5b5a59585756555453525150
F 06 6f6e6d6c6b6a69686766656463626160
F 07 7f7e7d7c7b7a79787776757473727170
F 08 8f8e8d8c8b8a89888786858483828180
F 09 9f9e9d9c9b9a99989796959493929190
I 04 1 05
G 04 0 0
I 08 0 03
I 09 0 09
I 0a 0 01
I 0b 0 07
I 0c 0 00
I 0d 0 06
I 0e 0 04
I 0f 1 02
G 08 0 0
G 08 60 0
I 10 0 07
I 11 0 07
I 12 0 00
I 13 0 05
I 14 0 02
I 15 1 06
G 10 85 0
I 3d 0 02
I 3e 0 08
I 3f 0 02
I 00 0 09
I 01 1 05
G 3d 0 0
G 08 30 1
G 10 50 1

/* sources.f */
+incdir+.
buffer_pkg.sv
sram_macro.sv
delay_line.sv
sram_port.sv
gather_engine.sv
gather_buffer_top.sv
gather_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the gather buffer testbench with verilator, run it, check the log
verilator --binary --timing --top-module gather_tb -f sources.f -o gather_sim \
    && ./obj_dir/gather_sim > sim.log 2>&1 \
    ; cat sim.log \
    && grep -q "STATUS: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
